// ==== alu_dpath.sv ====
// Shared ALU datapath with one adder, logic ops, shifter and branch comparator
`timescale 1ns/1ps
`default_nettype none

module alu_dpath
  import alu_pkg::*;
(
  input  rglr_op_t   i_op,
  input  xlen_t      i_op1,
  input  xlen_t      i_op2,
  input  bjp_op_t    i_cmp_op,
  input  logic       i_mdv_busy,   // Multiply owns the adder
  input  xlen_t      i_mdv_add1,
  input  xlen_t      i_mdv_add2,
  output xlen_t      o_res,
  output logic       o_cmp,
  output adder_res_t o_mdv_sum
);

  logic       do_sub;
  logic       add_cin;
  xlen_t      add_a;
  xlen_t      add_b;
  adder_res_t add_res;
  logic       cmp_eq;
  logic       cmp_lt;
  logic       cmp_ltu;
  logic [4:0] shamt;

  //////////////////////////////////////////////////////////////////////
  // Adder that subtracts as op1 + ~op2 + 1

  assign do_sub = (i_op == OP_SUB) | (i_op == OP_SLT) | (i_op == OP_SLTU);

  always_comb begin
    if (i_mdv_busy) begin
      add_a   = i_mdv_add1;
      add_b   = i_mdv_add2;
      add_cin = 1'b0;
    end else begin
      add_a   = i_op1;
      add_b   = do_sub ? ~i_op2 : i_op2;
      add_cin = do_sub;
    end
  end

  assign add_res   = {1'b0, add_a} + {1'b0, add_b} + adder_res_t'(add_cin);
  assign o_mdv_sum = add_res;

  // Compare flags hold only while subtracting
  assign cmp_eq  = (add_res[XLEN-1:0] == '0);
  assign cmp_ltu = ~add_res[XLEN];           // No carry out means borrow
  assign cmp_lt  = (i_op1[XLEN-1] ^ i_op2[XLEN-1]) ? i_op1[XLEN-1] : add_res[XLEN-1];

  //////////////////////////////////////////////////////////////////////
  // Result mux

  assign shamt = i_op2[4:0];

  always_comb begin
    case (i_op)
      OP_ADD,
      OP_SUB:  o_res = add_res[XLEN-1:0];
      OP_XOR:  o_res = i_op1 ^ i_op2;
      OP_OR:   o_res = i_op1 | i_op2;
      OP_AND:  o_res = i_op1 & i_op2;
      OP_SLL:  o_res = i_op1 << shamt;
      OP_SRL:  o_res = i_op1 >> shamt;
      OP_SRA:  o_res = xlen_t'($signed(i_op1) >>> shamt);
      OP_SLT:  o_res = xlen_t'(cmp_lt);
      OP_SLTU: o_res = xlen_t'(cmp_ltu);
      OP_LUI:  o_res = i_op2;                // Upper immediate comes in pre-shifted
      default: o_res = '0;
    endcase
  end

  // Branch condition
  always_comb begin
    case (i_cmp_op)
      BJP_EQ:   o_cmp = cmp_eq;
      BJP_NE:   o_cmp = ~cmp_eq;
      BJP_LT:   o_cmp = cmp_lt;
      BJP_GE:   o_cmp = ~cmp_lt;
      BJP_LTU:  o_cmp = cmp_ltu;
      BJP_GEU:  o_cmp = ~cmp_ltu;
      BJP_JAL,
      BJP_JALR: o_cmp = 1'b1;                // Jumps always taken
      default:  o_cmp = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== alu_issue.sv ====
// Issue logic steering one instruction to its unit and driving commit and write-back
`timescale 1ns/1ps
`default_nettype none

module alu_issue
  import alu_pkg::*;
(
  input  logic     i_valid,
  input  dec_grp_t i_grp,
  input  op_field_t i_op,
  input  xlen_t    i_rs1,
  input  xlen_t    i_rs2,
  input  xlen_t    i_imm,
  input  logic     i_use_imm,
  input  pc_t      i_pc,
  input  rfidx_t   i_rdidx,
  input  logic     i_rdwen,
  input  logic     i_ilegl,
  input  logic     i_bjp_prdt,
  input  logic     i_cmt_ready,
  input  logic     i_wbck_ready,
  input  xlen_t    i_dp_res,
  input  logic     i_dp_cmp,
  input  logic     i_mdv_done,
  input  xlen_t    i_mdv_prod,
  output logic     o_ready,
  output logic     o_cmt_valid,
  output pc_t      o_cmt_pc,
  output logic     o_cmt_bjp,
  output logic     o_cmt_bjp_prdt,
  output logic     o_cmt_bjp_rslv,
  output logic     o_cmt_ilegl,
  output logic     o_wbck_valid,
  output xlen_t    o_wbck_wdat,
  output rfidx_t   o_wbck_rdidx,
  output rglr_op_t o_dp_op,
  output xlen_t    o_dp_op1,
  output xlen_t    o_dp_op2,
  output bjp_op_t  o_dp_cmp_op,
  output logic     o_mdv_req,
  output logic     o_mdv_accept
);

  logic    rglr_sel;
  logic    bjp_sel;
  logic    mdv_sel;
  logic    need_wbck;
  logic    res_done;
  logic    out_valid;
  logic    bjp_taken;
  bjp_op_t bjp_op;
  pc_t     link_pc;

  //////////////////////////////////////////////////////////////////////
  // Group decode with no unit for an illegal fetch

  assign rglr_sel = ~i_ilegl & (i_grp == GRP_RGLR);
  assign bjp_sel  = ~i_ilegl & (i_grp == GRP_BJP);
  assign mdv_sel  = ~i_ilegl & (i_grp == GRP_MDV);

  assign bjp_op = bjp_op_t'(i_op);

  // Branches borrow the subtractor for their compare
  assign o_dp_op     = rglr_sel ? rglr_op_t'(i_op) : (bjp_sel ? OP_SUB : OP_ADD);
  assign o_dp_op1    = i_rs1;
  assign o_dp_op2    = i_use_imm ? i_imm : i_rs2;
  assign o_dp_cmp_op = bjp_op;

  assign link_pc   = i_pc + PC_SIZE'(4);
  assign bjp_taken = (bjp_op == BJP_JAL) | (bjp_op == BJP_JALR) | i_dp_cmp;

  //////////////////////////////////////////////////////////////////////
  // Result select

  always_comb begin
    if (rglr_sel) begin
      o_wbck_wdat = i_dp_res;
    end else if (bjp_sel) begin
      o_wbck_wdat = xlen_t'(link_pc);      // Link address
    end else if (mdv_sel) begin
      o_wbck_wdat = i_mdv_prod;
    end else begin
      o_wbck_wdat = '0;
    end
  end

  assign o_wbck_rdidx = i_rdidx;

  //////////////////////////////////////////////////////////////////////
  // Commit and write-back handshake

  assign need_wbck = i_rdwen & ~i_ilegl;
  assign res_done  = i_ilegl | rglr_sel | bjp_sel | (mdv_sel & i_mdv_done);
  assign out_valid = i_valid & res_done;

  assign o_cmt_valid  = out_valid & (~need_wbck | i_wbck_ready);
  assign o_wbck_valid = out_valid & need_wbck & i_cmt_ready;
  assign o_ready      = res_done & i_cmt_ready & (~need_wbck | i_wbck_ready);

  assign o_cmt_pc       = i_pc;
  assign o_cmt_bjp      = bjp_sel;
  assign o_cmt_bjp_prdt = bjp_sel & i_bjp_prdt;
  assign o_cmt_bjp_rslv = bjp_sel & bjp_taken;
  assign o_cmt_ilegl    = i_ilegl;

  // Multiply request level and the accept pulse that releases it
  assign o_mdv_req    = i_valid & mdv_sel;
  assign o_mdv_accept = i_valid & mdv_sel & o_ready;

endmodule

`default_nettype wire

// ==== alu_pkg.sv ====
// Shared widths, decode encodings and multiply constants for the execute-stage ALU
`default_nettype none

package alu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Word widths

  localparam int XLEN        = 32;
  localparam int PC_SIZE     = 32;
  localparam int RFIDX_WIDTH = 5;

  typedef logic [XLEN-1:0]        xlen_t;
  typedef logic [PC_SIZE-1:0]     pc_t;
  typedef logic [RFIDX_WIDTH-1:0] rfidx_t;
  typedef logic [XLEN:0]          adder_res_t;  // Sum plus carry out

  //////////////////////////////////////////////////////////////////////
  // Decode info

  typedef enum logic [1:0] {
    GRP_RGLR = 2'd0,
    GRP_BJP  = 2'd1,
    GRP_MDV  = 2'd2
  } dec_grp_t;

  // Raw op field decoded per group
  typedef logic [3:0] op_field_t;

  typedef enum logic [3:0] {
    OP_ADD, OP_SUB, OP_XOR, OP_SLL, OP_SRL, OP_SRA,
    OP_OR, OP_AND, OP_SLT, OP_SLTU, OP_LUI
  } rglr_op_t;

  typedef enum logic [3:0] {
    BJP_EQ, BJP_NE, BJP_LT, BJP_GE,
    BJP_LTU, BJP_GEU, BJP_JAL, BJP_JALR
  } bjp_op_t;

  typedef enum logic [3:0] {
    MDV_MUL   = 4'd0,  // Low word
    MDV_MULHU = 4'd1   // Unsigned high word
  } mdv_op_t;

  //////////////////////////////////////////////////////////////////////
  // Shift-and-add multiply

  localparam int MDV_STEPS     = 32;
  localparam int MDV_CNT_WIDTH = 6;

endpackage

`default_nettype wire

// ==== exu_alu.sv ====
// Execute-stage ALU top with regular, branch and shared-adder multiply units
`timescale 1ns/1ps
`default_nettype none

module exu_alu
  import alu_pkg::*;
(
  input  logic      clk,
  input  logic      i_reset,
  input  logic      i_valid,
  output logic      o_ready,
  input  dec_grp_t  i_grp,
  input  op_field_t i_op,
  input  xlen_t     i_rs1,
  input  xlen_t     i_rs2,
  input  xlen_t     i_imm,
  input  logic      i_use_imm,
  input  pc_t       i_pc,
  input  rfidx_t    i_rdidx,
  input  logic      i_rdwen,
  input  logic      i_ilegl,
  input  logic      i_bjp_prdt,
  output logic      o_cmt_valid,
  input  logic      i_cmt_ready,
  output pc_t       o_cmt_pc,
  output logic      o_cmt_bjp,
  output logic      o_cmt_bjp_prdt,
  output logic      o_cmt_bjp_rslv,
  output logic      o_cmt_ilegl,
  output logic      o_wbck_valid,
  input  logic      i_wbck_ready,
  output xlen_t     o_wbck_wdat,
  output rfidx_t    o_wbck_rdidx
);

  rglr_op_t   dp_op;
  xlen_t      dp_op1;
  xlen_t      dp_op2;
  bjp_op_t    dp_cmp_op;
  xlen_t      dp_res;
  logic       dp_cmp;
  adder_res_t mdv_sum;
  xlen_t      mdv_add1;
  xlen_t      mdv_add2;
  xlen_t      mdv_prod;
  logic       mdv_req;
  logic       mdv_accept;
  logic       mdv_busy;
  logic       mdv_done;
  logic       cnt_clr;
  logic       cnt_step;
  logic       cnt_last;
  logic       prod_load;
  logic       prod_step;

  //////////////////////////////////////////////////////////////////////
  // Issue and shared datapath

  alu_issue u_alu_issue (
    .i_valid        (i_valid),        .i_grp          (i_grp),
    .i_op           (i_op),           .i_rs1          (i_rs1),
    .i_rs2          (i_rs2),          .i_imm          (i_imm),
    .i_use_imm      (i_use_imm),      .i_pc           (i_pc),
    .i_rdidx        (i_rdidx),        .i_rdwen        (i_rdwen),
    .i_ilegl        (i_ilegl),        .i_bjp_prdt     (i_bjp_prdt),
    .i_cmt_ready    (i_cmt_ready),    .i_wbck_ready   (i_wbck_ready),
    .i_dp_res       (dp_res),         .i_dp_cmp       (dp_cmp),
    .i_mdv_done     (mdv_done),       .i_mdv_prod     (mdv_prod),
    .o_ready        (o_ready),        .o_cmt_valid    (o_cmt_valid),
    .o_cmt_pc       (o_cmt_pc),       .o_cmt_bjp      (o_cmt_bjp),
    .o_cmt_bjp_prdt (o_cmt_bjp_prdt), .o_cmt_bjp_rslv (o_cmt_bjp_rslv),
    .o_cmt_ilegl    (o_cmt_ilegl),    .o_wbck_valid   (o_wbck_valid),
    .o_wbck_wdat    (o_wbck_wdat),    .o_wbck_rdidx   (o_wbck_rdidx),
    .o_dp_op        (dp_op),          .o_dp_op1       (dp_op1),
    .o_dp_op2       (dp_op2),         .o_dp_cmp_op    (dp_cmp_op),
    .o_mdv_req      (mdv_req),        .o_mdv_accept   (mdv_accept)
  );

  alu_dpath u_alu_dpath (
    .i_op       (dp_op),    .i_op1      (dp_op1),   .i_op2      (dp_op2),
    .i_cmp_op   (dp_cmp_op), .i_mdv_busy (mdv_busy),
    .i_mdv_add1 (mdv_add1), .i_mdv_add2 (mdv_add2),
    .o_res      (dp_res),   .o_cmp      (dp_cmp),   .o_mdv_sum  (mdv_sum)
  );

  //////////////////////////////////////////////////////////////////////
  // Multiply

  mdv_ctrl u_mdv_ctrl (
    .clk        (clk),       .i_reset     (i_reset),
    .i_req      (mdv_req),   .i_accept    (mdv_accept), .i_last (cnt_last),
    .o_busy     (mdv_busy),  .o_done      (mdv_done),
    .o_cnt_clr  (cnt_clr),   .o_cnt_step  (cnt_step),
    .o_prod_load(prod_load), .o_prod_step (prod_step)
  );

  mdv_step_counter u_mdv_step_counter (
    .clk (clk), .i_reset (i_reset), .i_clr (cnt_clr), .i_step (cnt_step), .o_last (cnt_last)
  );

  mdv_product_reg u_mdv_product_reg (
    .clk      (clk),       .i_reset (i_reset),
    .i_load   (prod_load), .i_step  (prod_step),
    .i_rs1    (i_rs1),     .i_rs2   (i_rs2),
    .i_mdv_op (mdv_op_t'(i_op)),    // Op field read as a multiply op
    .i_sum    (mdv_sum),
    .o_add1   (mdv_add1),  .o_add2  (mdv_add2), .o_prod (mdv_prod)
  );

endmodule

`default_nettype wire

// ==== mdv_ctrl.sv ====
// Multiply FSM sequencing load, 32 shift-add steps and the result hold
`timescale 1ns/1ps
`default_nettype none

module mdv_ctrl
  import alu_pkg::*;
(
  input  logic clk,
  input  logic i_reset,
  input  logic i_req,
  input  logic i_accept,
  input  logic i_last,
  output logic o_busy,
  output logic o_done,
  output logic o_cnt_clr,
  output logic o_cnt_step,
  output logic o_prod_load,
  output logic o_prod_step
);

  typedef enum logic [1:0] {
    IDLE,
    RUN,
    DONE
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   start;

  assign start = (state_q == IDLE) & i_req;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (i_req)    state_d = RUN;
      RUN:     if (i_last)   state_d = DONE;   // Last step this cycle
      DONE:    if (i_accept) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_reset) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Strobes

  assign o_busy      = (state_q == RUN);
  assign o_done      = (state_q == DONE);
  assign o_cnt_clr   = start;
  assign o_prod_load = start;
  assign o_cnt_step  = o_busy;
  assign o_prod_step = o_busy;

  // Accept only arrives for a product that is already held
  assert property (@(posedge clk) disable iff (i_reset) i_accept |-> o_done)
    else $error("multiply accepted before its result was done");

  // Issue side keeps the request up until the product is taken
  assert property (@(posedge clk) disable iff (i_reset) (o_busy || o_done) |-> i_req)
    else $error("multiply request dropped while the product was pending");

endmodule

`default_nettype wire

// ==== mdv_product_reg.sv ====
// Two-word product register for the unsigned shift-and-add multiply
`timescale 1ns/1ps
`default_nettype none

module mdv_product_reg
  import alu_pkg::*;
(
  input  logic       clk,
  input  logic       i_reset,
  input  logic       i_load,
  input  logic       i_step,
  input  xlen_t      i_rs1,      // Multiplicand
  input  xlen_t      i_rs2,      // Multiplier
  input  mdv_op_t    i_mdv_op,
  input  adder_res_t i_sum,
  output xlen_t      o_add1,
  output xlen_t      o_add2,
  output xlen_t      o_prod
);

  xlen_t hi_q;
  xlen_t lo_q;

  // Add the multiplicand only when the current multiplier bit is set
  assign o_add1 = hi_q;
  assign o_add2 = lo_q[0] ? i_rs1 : '0;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      hi_q <= '0;
      lo_q <= '0;
    end else if (i_load) begin
      hi_q <= '0;
      lo_q <= i_rs2;
    end else if (i_step) begin
      // Carry lands at the top, sum low bit moves into the low word
      {hi_q, lo_q} <= {i_sum, lo_q[XLEN-1:1]};
    end
  end

  assign o_prod = (i_mdv_op == MDV_MULHU) ? hi_q : lo_q;

endmodule

`default_nettype wire

// ==== mdv_step_counter.sv ====
// Multiply step counter that flags the last of MDV_STEPS iterations
`timescale 1ns/1ps
`default_nettype none

module mdv_step_counter
  import alu_pkg::*;
(
  input  logic clk,
  input  logic i_reset,
  input  logic i_clr,
  input  logic i_step,
  output logic o_last
);

  logic [MDV_CNT_WIDTH-1:0] cnt_q;

  assign o_last = (cnt_q == MDV_CNT_WIDTH'(MDV_STEPS - 1));

  always_ff @(posedge clk) begin
    if (i_reset | i_clr) begin
      cnt_q <= '0;
    end else if (i_step) begin
      cnt_q <= o_last ? '0 : cnt_q + 1'b1;  // Wraps after the last step
    end
  end

  // Sequencer must stop stepping once the last count is taken
  assert property (@(posedge clk) disable iff (i_reset) (i_step && o_last) |=> !i_step)
    else $error("multiply stepped past its last iteration");

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run the testbench and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_exu_alu -o tb_exu_alu
./obj_dir/tb_exu_alu > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
  exit 1
fi
exit 0

// ==== sim.f ====
+incdir+.
alu_pkg.sv
alu_dpath.sv
alu_issue.sv
mdv_ctrl.sv
mdv_step_counter.sv
mdv_product_reg.sv
exu_alu.sv
tb_exu_alu.sv

// ==== tb_alu_model.svh ====
// Reference model of the ALU instruction rules and typed compare tasks for the testbench

// Regular op result from the instruction rules
function automatic xlen_t model_rglr(rglr_op_t op, xlen_t a, xlen_t b);
  case (op)
    OP_ADD:  return a + b;
    OP_SUB:  return a - b;
    OP_XOR:  return a ^ b;
    OP_SLL:  return a << b[4:0];
    OP_SRL:  return a >> b[4:0];
    OP_SRA:  return xlen_t'($signed(a) >>> b[4:0]);
    OP_OR:   return a | b;
    OP_AND:  return a & b;
    OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
    OP_LUI:  return b;                     // Immediate already in place
    default: return '0;
  endcase
endfunction

// Branch condition with jumps always taken
function automatic logic model_taken(bjp_op_t op, xlen_t a, xlen_t b);
  case (op)
    BJP_EQ:   return a == b;
    BJP_NE:   return a != b;
    BJP_LT:   return $signed(a) < $signed(b);
    BJP_GE:   return $signed(a) >= $signed(b);
    BJP_LTU:  return a < b;
    BJP_GEU:  return a >= b;
    BJP_JAL,
    BJP_JALR: return 1'b1;
    default:  return 1'b0;
  endcase
endfunction

// One word of the full unsigned product as picked by the op
function automatic xlen_t model_mul(mdv_op_t op, xlen_t a, xlen_t b);
  logic [2*XLEN-1:0] p;
  p = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
  return (op == MDV_MULHU) ? p[2*XLEN-1:XLEN] : p[XLEN-1:0];
endfunction

//////////////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_word(input string name, input xlen_t got, input xlen_t exp);
  if (got !== exp) begin
    $display("error: %s = 0x%08h, expected 0x%08h", name, got, exp);
    value_errs++;
  end
endtask

task automatic check_idx(input string name, input rfidx_t got, input rfidx_t exp);
  if (got !== exp) begin
    $display("error: %s = 0x%02h, expected 0x%02h", name, got, exp);
    value_errs++;
  end
endtask

task automatic check_flag(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    $display("error: %s = 0x%0h, expected 0x%0h", name, got, exp);
    value_errs++;
  end
endtask

// ==== tb_exu_alu.sv ====
// Testbench for the execute-stage ALU with random instructions under random back-pressure
`timescale 1ns/1ps
`default_nettype none

module tb_exu_alu
  import alu_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int N_INSTR    = 120;

  logic      clk = 1'b0;
  logic      i_reset;
  logic      i_valid;
  logic      i_use_imm;
  logic      i_rdwen;
  logic      i_ilegl;
  logic      i_bjp_prdt;
  logic      i_cmt_ready;
  logic      i_wbck_ready;
  dec_grp_t  i_grp;
  op_field_t i_op;
  xlen_t     i_rs1;
  xlen_t     i_rs2;
  xlen_t     i_imm;
  pc_t       i_pc;
  rfidx_t    i_rdidx;
  logic      o_ready;
  logic      o_cmt_valid;
  logic      o_cmt_bjp;
  logic      o_cmt_bjp_prdt;
  logic      o_cmt_bjp_rslv;
  logic      o_cmt_ilegl;
  logic      o_wbck_valid;
  pc_t       o_cmt_pc;
  xlen_t     o_wbck_wdat;
  rfidx_t    o_wbck_rdidx;

  integer seed;
  int     value_errs;
  int     proto_errs;
  xlen_t  exp_wdat;
  logic   need_wb;
  logic   is_mul;
  logic   exp_bjp;
  logic   exp_taken;

  `include "tb_alu_model.svh"

  always #(CLK_PERIOD / 2) clk = ~clk;

  exu_alu uut (.*);

  //////////////////////////////////////////////////////////////////////
  // Stimulus and expected results

  // Random instruction on the DUT inputs with its model results
  task automatic gen_instr();
    logic [31:0] r;
    xlen_t       op2;
    r          = $random(seed);
    i_rs1      = $random(seed);
    i_rs2      = (r[22:20] == 3'd0) ? i_rs1 : $random(seed);  // Equal operands now and then
    i_imm      = $random(seed);
    i_use_imm  = r[3];
    i_pc       = $random(seed) & 32'hffff_fffc;
    i_rdidx    = r[8:4];
    i_rdwen    = (r[11:9] != 3'd0);
    i_ilegl    = (r[14:12] == 3'd0);
    i_bjp_prdt = r[15];
    if (r[2:0] < 3'd4) begin
      i_grp = GRP_RGLR;
      i_op  = op_field_t'(r[23:16] % 8'd11);
    end else if (r[2:0] < 3'd6) begin
      i_grp = GRP_BJP;
      i_op  = {1'b0, r[18:16]};
    end else begin
      i_grp = GRP_MDV;
      i_op  = {3'b0, r[16]};
    end
    op2       = i_use_imm ? i_imm : i_rs2;
    need_wb   = i_rdwen & ~i_ilegl;
    is_mul    = (i_grp == GRP_MDV) & ~i_ilegl;
    exp_bjp   = (i_grp == GRP_BJP) & ~i_ilegl;
    exp_taken = model_taken(bjp_op_t'(i_op), i_rs1, op2);
    case (i_grp)
      GRP_RGLR: exp_wdat = model_rglr(rglr_op_t'(i_op), i_rs1, op2);
      GRP_BJP:  exp_wdat = i_pc + 32'd4;                // Link address
      default:  exp_wdat = model_mul(mdv_op_t'(i_op), i_rs1, i_rs2);
    endcase
  endtask

  // Hold one instruction until accepted, checking the handshake each cycle
  task automatic run_instr(input int n);
    logic [31:0] r;
    int          cyc;
    int          cmts;
    logic        done;
    logic        accepted;
    cyc      = 0;
    cmts     = 0;
    accepted = 1'b0;
    gen_instr();
    i_valid = 1'b1;
    while (!accepted) begin
      r            = $random(seed);
      i_cmt_ready  = r[0];
      i_wbck_ready = r[1];
      #1;
      done = ~is_mul | (cyc >= MDV_STEPS + 1);   // Multiply done a fixed time after issue
      check_flag("o_cmt_valid", o_cmt_valid, done & (~need_wb | i_wbck_ready));
      check_flag("o_wbck_valid", o_wbck_valid, done & need_wb & i_cmt_ready);
      check_flag("o_ready", o_ready, done & i_cmt_ready & (~need_wb | i_wbck_ready));
      if (o_cmt_valid && i_cmt_ready) begin
        cmts++;
      end
      if (o_ready) begin
        accepted = 1'b1;
        if (need_wb) begin
          check_word("o_wbck_wdat", o_wbck_wdat, exp_wdat);
        end
        check_idx("o_wbck_rdidx", o_wbck_rdidx, i_rdidx);
        check_word("o_cmt_pc", o_cmt_pc, i_pc);
        check_flag("o_cmt_bjp", o_cmt_bjp, exp_bjp);
        check_flag("o_cmt_bjp_prdt", o_cmt_bjp_prdt, exp_bjp & i_bjp_prdt);
        check_flag("o_cmt_bjp_rslv", o_cmt_bjp_rslv, exp_bjp & exp_taken);
        check_flag("o_cmt_ilegl", o_cmt_ilegl, i_ilegl);
        if (cmts != 1) begin
          $display("Instruction %0d committed %0d times instead of once", n, cmts);
          proto_errs++;
        end
      end else begin
        @(negedge clk);
      end
      cyc++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence

  initial begin
    seed         = 33;
    value_errs   = 0;
    proto_errs   = 0;
    i_reset      = 1'b1;
    i_valid      = 1'b0;
    i_cmt_ready  = 1'b0;
    i_wbck_ready = 1'b0;
    gen_instr();                                 // Fills the remaining inputs
    repeat (5) @(posedge clk);
    @(negedge clk);
    i_reset = 1'b0;
    for (int n = 0; n < N_INSTR; n++) begin
      @(negedge clk);
      run_instr(n);
    end
    @(negedge clk);
    i_valid = 1'b0;
    #1;
    check_flag("o_cmt_valid", o_cmt_valid, 1'b0);   // Nothing valid without an instruction
    check_flag("o_wbck_valid", o_wbck_valid, 1'b0);
    $display("Done: %0d value errors, %0d protocol errors", value_errs, proto_errs);
    if (value_errs == 0 && proto_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  // Every instruction gets a multiply's worth of cycles plus slack
  initial begin
    #((N_INSTR * (MDV_STEPS + 10) + 10) * CLK_PERIOD);
    $display("Timeout: the instruction stream did not finish in time");
    $display("Test failures found");
    $finish;
  end

endmodule

`default_nettype wire
